/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_backend -f compile.f -o tb_sim
	out="$$(./obj_dir/tb_sim)"; echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

/* compile.f */
src/backend_pkg.sv
src/forward_mux.sv
src/exec_alu.sv
src/mem_stage.sv
src/issue_decoder.sv
src/backend_pipeline.sv
src/reg_file.sv
src/core_backend.sv
verif/tb_clock.sv
verif/backend_properties.sv
verif/tb_backend.sv

/* src/backend_pipeline.sv */
module backend_pipeline (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  id_valid_i,
	input  backend_pkg::opcode_e  id_op_i,
	input  backend_pkg::reg_idx_t id_rd_i,
	input  backend_pkg::reg_idx_t id_rs1_i,
	input  backend_pkg::reg_idx_t id_rs2_i,
	input  backend_pkg::imm_t     id_imm_i,
	input  backend_pkg::word_t    id_pc_i,
	input  backend_pkg::word_t    id_rs1_data_i,
	input  backend_pkg::word_t    id_rs2_data_i,
	input  backend_pkg::fwd_sel_e id_fwd1_i,
	input  backend_pkg::fwd_sel_e id_fwd2_i,
	output logic                  squash_o,
	output logic                  redirect_o,
	output backend_pkg::word_t    redirect_pc_o,
	output backend_pkg::reg_idx_t ex_rd_o,
	output logic                  ex_is_load_o,
	output backend_pkg::reg_idx_t m1_rd_o,
	output backend_pkg::reg_idx_t m2_rd_o,
	output logic                  wb_valid_o,
	output backend_pkg::reg_idx_t wb_addr_o,
	output backend_pkg::word_t    wb_data_o
);

	// rd fields below are zero for anything that does not write a register
	logic                  ex_valid, m1_valid, m2_valid, wb_valid_q;
	backend_pkg::opcode_e  ex_op, m1_op;
	backend_pkg::reg_idx_t ex_rd, m1_rd, m2_rd, wb_rd;
	backend_pkg::fwd_sel_e ex_fwd1, ex_fwd2;
	backend_pkg::reg_idx_t ex_rs1, ex_rs2;
	backend_pkg::word_t    ex_rs1_data, ex_rs2_data, ex_pc;
	backend_pkg::imm_t     ex_imm;
	backend_pkg::word_t    fwd_a, fwd_b, op_a, op_b;
	backend_pkg::word_t    alu_result, alu_addr;
	logic                  alu_taken;
	backend_pkg::word_t    m1_result, m1_addr, m1_wdata, m2_result, wb_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_op    <= backend_pkg::NOP;
			ex_rd    <= '0;
			ex_fwd1  <= backend_pkg::FWD_NONE;
			ex_fwd2  <= backend_pkg::FWD_NONE;
		end else begin
			// id_valid_i drops on stall or squash, so EX takes a bubble
			ex_valid <= id_valid_i;
			ex_op    <= id_valid_i ? id_op_i : backend_pkg::NOP;
			ex_rd    <= (id_valid_i && backend_pkg::writes_rd(id_op_i)) ? id_rd_i : '0;
			ex_fwd1  <= id_valid_i ? id_fwd1_i : backend_pkg::FWD_NONE;
			ex_fwd2  <= id_valid_i ? id_fwd2_i : backend_pkg::FWD_NONE;
		end
	end

	always_ff @(posedge clk) begin
		ex_rs1      <= id_rs1_i;
		ex_rs2      <= id_rs2_i;
		ex_rs1_data <= id_rs1_data_i;
		ex_rs2_data <= id_rs2_data_i;
		ex_imm      <= id_imm_i;
		ex_pc       <= id_pc_i;
	end

	forward_mux i_fwd_a (.sel_i(ex_fwd1), .raw_i(ex_rs1_data),
		.m1_i(m1_result), .m2_i(m2_result), .wb_i(wb_data), .data_o(fwd_a));
	forward_mux i_fwd_b (.sel_i(ex_fwd2), .raw_i(ex_rs2_data),
		.m1_i(m1_result), .m2_i(m2_result), .wb_i(wb_data), .data_o(fwd_b));

	assign op_a = (ex_rs1 == '0) ? '0 : fwd_a;  // x0 stays zero
	assign op_b = (ex_rs2 == '0) ? '0 : fwd_b;

	exec_alu i_exec_alu (.op_i(ex_op), .a_i(op_a), .b_i(op_b), .imm_i(ex_imm),
		.pc_i(ex_pc), .result_o(alu_result), .addr_o(alu_addr), .taken_o(alu_taken),
		.target_o(redirect_pc_o));

	// taken beq: pulse during EX, ID is dropped at the next edge
	assign redirect_o = ex_valid && alu_taken;
	assign squash_o   = redirect_o;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_valid   <= 1'b0;
			m1_op      <= backend_pkg::NOP;
			m1_rd      <= '0;
			m2_valid   <= 1'b0;
			m2_rd      <= '0;
			wb_valid_q <= 1'b0;
			wb_rd      <= '0;
		end else begin
			m1_valid   <= ex_valid;
			m1_op      <= ex_op;
			m1_rd      <= ex_rd;
			m2_valid   <= m1_valid;
			m2_rd      <= m1_rd;
			wb_valid_q <= m2_valid && (m2_rd != '0);
			wb_rd      <= m2_rd;
		end
	end

	always_ff @(posedge clk) begin
		m1_result <= alu_result;
		m1_addr   <= alu_addr;
		m1_wdata  <= op_b;  // store data after forwarding
		wb_data   <= m2_result;
	end

	mem_stage i_mem_stage (.clk(clk), .rst_n(rst_n), .m1_valid_i(m1_valid),
		.m1_op_i(m1_op), .m1_addr_i(m1_addr), .m1_wdata_i(m1_wdata),
		.m1_result_i(m1_result), .m2_result_o(m2_result));

	assign ex_rd_o      = ex_rd;
	assign ex_is_load_o = (ex_op == backend_pkg::LW);
	assign m1_rd_o      = m1_rd;
	assign m2_rd_o      = m2_rd;

	assign wb_valid_o = wb_valid_q;
	assign wb_addr_o  = wb_rd;
	assign wb_data_o  = wb_data;

endmodule

/* src/backend_pkg.sv */
package backend_pkg;

	localparam int XLEN       = 32;
	localparam int REG_IDX_W  = 4;
	localparam int IMM_W      = 16;
	localparam int NUM_REGS   = 16;
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// instruction layout, msb first: op | rd | rs1 | rs2 | imm
	localparam int OP_LSB  = 28;
	localparam int RD_LSB  = 24;
	localparam int RS1_LSB = 20;
	localparam int RS2_LSB = 16;

	typedef logic [XLEN-1:0]      word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [IMM_W-1:0]     imm_t;
	typedef logic [31:0]          instr_t;

	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		ADDI = 4'd6,
		LW   = 4'd7,
		SW   = 4'd8,
		BEQ  = 4'd9
	} opcode_e;

	// operand source for EX, named by where the producer sits at EX time
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_M1   = 2'd1,
		FWD_M2   = 2'd2,
		FWD_WB   = 2'd3
	} fwd_sel_e;

	function automatic logic writes_rd(opcode_e op);
		case (op)
			ADD, SUB, AND, OR, XOR, ADDI, LW: writes_rd = 1'b1;
			default:                          writes_rd = 1'b0;
		endcase
	endfunction

	function automatic logic reads_rs2(opcode_e op);
		case (op)
			ADD, SUB, AND, OR, XOR, SW, BEQ: reads_rs2 = 1'b1;
			default:                         reads_rs2 = 1'b0;
		endcase
	endfunction

endpackage

/* src/core_backend.sv */
module core_backend (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue_i,
	input  backend_pkg::instr_t   instr_i,
	input  backend_pkg::word_t    pc_i,
	output logic                  stall_o,
	output logic                  redirect_o,
	output backend_pkg::word_t    redirect_pc_o,
	output logic                  wb_valid_o,
	output backend_pkg::reg_idx_t wb_addr_o,
	output backend_pkg::word_t    wb_data_o
);

	logic                  id_valid, ex_is_load, squash;
	backend_pkg::opcode_e  id_op;
	backend_pkg::reg_idx_t id_rd, id_rs1, id_rs2, ex_rd, m1_rd, m2_rd;
	backend_pkg::reg_idx_t rf_raddr1, rf_raddr2;
	backend_pkg::imm_t     id_imm;
	backend_pkg::word_t    id_pc, id_rs1_data, id_rs2_data, rf_rdata1, rf_rdata2;
	backend_pkg::fwd_sel_e id_fwd1, id_fwd2;

	issue_decoder i_issue_decoder (.clk(clk), .rst_n(rst_n), .issue_i(issue_i),
		.instr_i(instr_i), .pc_i(pc_i), .rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
		.rf_raddr1_o(rf_raddr1), .rf_raddr2_o(rf_raddr2), .ex_rd_i(ex_rd),
		.ex_is_load_i(ex_is_load), .m1_rd_i(m1_rd), .m2_rd_i(m2_rd), .squash_i(squash),
		.stall_o(stall_o), .id_valid_o(id_valid), .id_op_o(id_op), .id_rd_o(id_rd),
		.id_rs1_o(id_rs1), .id_rs2_o(id_rs2), .id_imm_o(id_imm), .id_pc_o(id_pc),
		.id_rs1_data_o(id_rs1_data), .id_rs2_data_o(id_rs2_data),
		.id_fwd1_o(id_fwd1), .id_fwd2_o(id_fwd2));

	backend_pipeline i_backend_pipeline (.clk(clk), .rst_n(rst_n), .id_valid_i(id_valid),
		.id_op_i(id_op), .id_rd_i(id_rd), .id_rs1_i(id_rs1), .id_rs2_i(id_rs2),
		.id_imm_i(id_imm), .id_pc_i(id_pc), .id_rs1_data_i(id_rs1_data),
		.id_rs2_data_i(id_rs2_data), .id_fwd1_i(id_fwd1), .id_fwd2_i(id_fwd2),
		.squash_o(squash), .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o),
		.ex_rd_o(ex_rd), .ex_is_load_o(ex_is_load), .m1_rd_o(m1_rd), .m2_rd_o(m2_rd),
		.wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o));

	reg_file i_reg_file (.clk(clk), .rst_n(rst_n), .we_i(wb_valid_o), .waddr_i(wb_addr_o),
		.wdata_i(wb_data_o), .raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
		.rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2));

endmodule

/* src/exec_alu.sv */
module exec_alu (
	input  backend_pkg::opcode_e op_i,
	input  backend_pkg::word_t   a_i,
	input  backend_pkg::word_t   b_i,
	input  backend_pkg::imm_t    imm_i,
	input  backend_pkg::word_t   pc_i,
	output backend_pkg::word_t   result_o,
	output backend_pkg::word_t   addr_o,
	output logic                 taken_o,
	output backend_pkg::word_t   target_o
);

	backend_pkg::word_t imm_sx;
	backend_pkg::word_t imm_x4;

	assign imm_sx = {{(backend_pkg::XLEN - backend_pkg::IMM_W){imm_i[backend_pkg::IMM_W-1]}},
		imm_i};
	assign imm_x4 = {imm_sx[backend_pkg::XLEN-3:0], 2'b00};  // word offset to bytes

	// agu, shared by lw and sw
	assign addr_o = a_i + imm_sx;

	assign taken_o  = (op_i == backend_pkg::BEQ) && (a_i == b_i);
	assign target_o = pc_i + imm_x4;

	always_comb begin
		case (op_i)
			backend_pkg::ADD:  result_o = a_i + b_i;
			backend_pkg::SUB:  result_o = a_i - b_i;
			backend_pkg::AND:  result_o = a_i & b_i;
			backend_pkg::OR:   result_o = a_i | b_i;
			backend_pkg::XOR:  result_o = a_i ^ b_i;
			backend_pkg::ADDI: result_o = a_i + imm_sx;
			backend_pkg::LW,
			backend_pkg::SW:   result_o = addr_o;  // replaced by load data in M1
			default:           result_o = '0;
		endcase
	end

endmodule

/* src/forward_mux.sv */
module forward_mux (
	input  backend_pkg::fwd_sel_e sel_i,
	input  backend_pkg::word_t    raw_i,
	input  backend_pkg::word_t    m1_i,
	input  backend_pkg::word_t    m2_i,
	input  backend_pkg::word_t    wb_i,
	output backend_pkg::word_t    data_o
);

	always_comb begin
		case (sel_i)
			backend_pkg::FWD_M1: data_o = m1_i;
			backend_pkg::FWD_M2: data_o = m2_i;
			backend_pkg::FWD_WB: data_o = wb_i;
			default:             data_o = raw_i;  // value read from the register file
		endcase
	end

endmodule

/* src/issue_decoder.sv */
module issue_decoder (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue_i,
	input  backend_pkg::instr_t   instr_i,
	input  backend_pkg::word_t    pc_i,
	input  backend_pkg::word_t    rf_rdata1_i,
	input  backend_pkg::word_t    rf_rdata2_i,
	output backend_pkg::reg_idx_t rf_raddr1_o,
	output backend_pkg::reg_idx_t rf_raddr2_o,
	input  backend_pkg::reg_idx_t ex_rd_i,
	input  logic                  ex_is_load_i,
	input  backend_pkg::reg_idx_t m1_rd_i,
	input  backend_pkg::reg_idx_t m2_rd_i,
	input  logic                  squash_i,
	output logic                  stall_o,
	output logic                  id_valid_o,
	output backend_pkg::opcode_e  id_op_o,
	output backend_pkg::reg_idx_t id_rd_o,
	output backend_pkg::reg_idx_t id_rs1_o,
	output backend_pkg::reg_idx_t id_rs2_o,
	output backend_pkg::imm_t     id_imm_o,
	output backend_pkg::word_t    id_pc_o,
	output backend_pkg::word_t    id_rs1_data_o,
	output backend_pkg::word_t    id_rs2_data_o,
	output backend_pkg::fwd_sel_e id_fwd1_o,
	output backend_pkg::fwd_sel_e id_fwd2_o
);

	logic                 id_valid_q;
	logic                 id_live;
	logic                 accept;
	logic                 hit_rs1;
	logic                 hit_rs2;
	logic [3:0]           raw_op;
	backend_pkg::opcode_e dec_op;

	// youngest producer wins, x0 never forwards
	function automatic backend_pkg::fwd_sel_e pick_fwd(backend_pkg::reg_idx_t src,
		backend_pkg::reg_idx_t ex_rd, backend_pkg::reg_idx_t m1_rd,
		backend_pkg::reg_idx_t m2_rd);
		if (src == '0)
			return backend_pkg::FWD_NONE;
		else if (src == ex_rd)
			return backend_pkg::FWD_M1;
		else if (src == m1_rd)
			return backend_pkg::FWD_M2;
		else if (src == m2_rd)
			return backend_pkg::FWD_WB;
		return backend_pkg::FWD_NONE;
	endfunction

	assign raw_op = instr_i[backend_pkg::OP_LSB +: 4];
	assign dec_op = (raw_op <= backend_pkg::BEQ) ? backend_pkg::opcode_e'(raw_op)
		: backend_pkg::NOP;  // unused encodings decode as nop

	assign accept = issue_i && !stall_o;

	always_ff @(posedge clk) begin
		if (!rst_n)
			id_valid_q <= 1'b0;
		else if (accept)
			id_valid_q <= 1'b1;
		else if (!stall_o)
			id_valid_q <= 1'b0;  // moved on to EX or was squashed
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			id_op_o  <= dec_op;
			id_rd_o  <= instr_i[backend_pkg::RD_LSB +: backend_pkg::REG_IDX_W];
			id_rs1_o <= instr_i[backend_pkg::RS1_LSB +: backend_pkg::REG_IDX_W];
			id_rs2_o <= instr_i[backend_pkg::RS2_LSB +: backend_pkg::REG_IDX_W];
			id_imm_o <= instr_i[backend_pkg::IMM_W-1:0];
			id_pc_o  <= pc_i;
		end
	end

	assign id_live = id_valid_q && !squash_i;  // a taken branch in EX kills ID

	// load-use: loaded value is not ready until M2
	assign hit_rs1 = (id_op_o != backend_pkg::NOP) && (id_rs1_o == ex_rd_i);
	assign hit_rs2 = backend_pkg::reads_rs2(id_op_o) && (id_rs2_o == ex_rd_i);
	assign stall_o = id_live && ex_is_load_i && (ex_rd_i != '0) && (hit_rs1 || hit_rs2);

	assign id_valid_o = id_live && !stall_o;  // low means a bubble into EX

	assign rf_raddr1_o   = id_rs1_o;
	assign rf_raddr2_o   = id_rs2_o;
	assign id_rs1_data_o = rf_rdata1_i;
	assign id_rs2_data_o = rf_rdata2_i;

	assign id_fwd1_o = pick_fwd(id_rs1_o, ex_rd_i, m1_rd_i, m2_rd_i);
	assign id_fwd2_o = pick_fwd(id_rs2_o, ex_rd_i, m1_rd_i, m2_rd_i);

endmodule

/* src/mem_stage.sv */
module mem_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 m1_valid_i,
	input  backend_pkg::opcode_e m1_op_i,
	input  backend_pkg::word_t   m1_addr_i,
	input  backend_pkg::word_t   m1_wdata_i,
	input  backend_pkg::word_t   m1_result_i,
	output backend_pkg::word_t   m2_result_o
);

	backend_pkg::word_t              dmem [backend_pkg::DMEM_WORDS];
	logic [backend_pkg::DMEM_AW-1:0] word_idx;
	backend_pkg::word_t              rdata;
	logic                            is_load;
	logic                            is_store;

	// byte address to word index, upper bits ignored so it wraps
	assign word_idx = m1_addr_i[backend_pkg::DMEM_AW+1:2];

	assign is_load  = m1_valid_i && (m1_op_i == backend_pkg::LW);
	assign is_store = m1_valid_i && (m1_op_i == backend_pkg::SW);

	assign rdata = dmem[word_idx];  // async read in M1

	always_ff @(posedge clk) begin
		if (is_store)
			dmem[word_idx] <= m1_wdata_i;
	end

	// M2 result register, also a forwarding source
	always_ff @(posedge clk) begin
		if (!rst_n)
			m2_result_o <= '0;
		else if (is_load)
			m2_result_o <= rdata;
		else
			m2_result_o <= m1_result_i;
	end

endmodule

/* src/reg_file.sv */
module reg_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  we_i,
	input  backend_pkg::reg_idx_t waddr_i,
	input  backend_pkg::word_t    wdata_i,
	input  backend_pkg::reg_idx_t raddr1_i,
	input  backend_pkg::reg_idx_t raddr2_i,
	output backend_pkg::word_t    rdata1_o,
	output backend_pkg::word_t    rdata2_o
);

	backend_pkg::word_t regs [backend_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < backend_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 hardwired, then same-cycle WB write bypasses the array
	assign rdata1_o = (raddr1_i == '0) ? '0
		: (we_i && (waddr_i == raddr1_i)) ? wdata_i
		: regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0
		: (we_i && (waddr_i == raddr2_i)) ? wdata_i
		: regs[raddr2_i];

endmodule

/* verif/backend_properties.sv */
module backend_properties (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  stall_o,
	input logic                  redirect_o,
	input logic                  wb_valid_o,
	input backend_pkg::reg_idx_t wb_addr_o
);

	// load-use bubble costs exactly one cycle
	stall_single: assert property (@(posedge clk) disable iff (!rst_n)
		stall_o |=> !stall_o)
		else $error("stall_o high on two consecutive cycles");

	wb_addr_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid_o |-> (wb_addr_o != '0))
		else $error("retire write to register 0");

	redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		redirect_o |=> !redirect_o)
		else $error("redirect_o longer than one cycle");

endmodule

bind core_backend backend_properties i_backend_properties (
	.clk(clk),
	.rst_n(rst_n),
	.stall_o(stall_o),
	.redirect_o(redirect_o),
	.wb_valid_o(wb_valid_o),
	.wb_addr_o(wb_addr_o)
);

/* verif/backend_testdata.hex */
// instr  retire  rd  value  redirect  target ; record n sits at pc n*4
// ffffffff in the instr column ends the stream
61000005 1 1 00000005 0 00000000
62000123 1 2 00000123 0 00000000
13120000 1 3 00000128 0 00000000
24310000 1 4 00000123 0 00000000
35430000 1 5 00000120 0 00000000
46510000 1 6 00000125 0 00000000
57620000 1 7 00000006 0 00000000
6870ffff 1 8 00000005 0 00000000
69000040 1 9 00000040 0 00000000
80930008 0 0 00000000 0 00000000
7a900008 1 a 00000128 0 00000000
1ba10000 1 b 0000012d 0 00000000
80080010 0 0 00000000 0 00000000
7c000010 1 c 00000005 0 00000000
1dcb0000 1 d 00000132 0 00000000
800d0020 0 0 00000000 0 00000000
7e000020 1 e 00000132 0 00000000
00000000 0 0 00000000 0 00000000
90180003 0 0 00000000 1 00000054
6f000077 0 0 00000000 0 00000000
6f000055 1 f 00000055 0 00000000
90120002 0 0 00000000 0 00000000
6e000099 1 e 00000099 0 00000000
60000033 0 0 00000000 0 00000000
15000000 1 5 00000000 0 00000000
66000007 1 6 00000007 0 00000000
9050fffe 0 0 00000000 1 00000060
67000001 0 0 00000000 0 00000000
67000002 1 7 00000002 0 00000000
ffffffff 0 0 00000000 0 00000000

/* verif/tb_backend.sv */
module tb_backend;

	localparam int REC_W       = 6;  // words per record
	localparam int MAX_RECS    = 48;
	localparam int STALL_LIMIT = 8;
	localparam int DRAIN_LIMIT = 50;
	localparam int RESET_LIMIT = 10;

	logic                  clk;
	logic                  rst_n;
	logic                  issue_i;
	backend_pkg::instr_t   instr_i;
	backend_pkg::word_t    pc_i;
	logic                  stall_o;
	logic                  redirect_o;
	backend_pkg::word_t    redirect_pc_o;
	logic                  wb_valid_o;
	backend_pkg::reg_idx_t wb_addr_o;
	backend_pkg::word_t    wb_data_o;

	logic [31:0] td [REC_W*MAX_RECS];
	int          retire_q[$];    // record indices, program order
	int          redirect_q[$];
	int          accept_edge [MAX_RECS];
	int          latency [MAX_RECS];
	int          cycle = 0;
	int          errors;
	int          checks;

	tb_clock i_tb_clock (.clk(clk), .rst_n(rst_n));

	core_backend i_core_backend (.clk(clk), .rst_n(rst_n), .issue_i(issue_i),
		.instr_i(instr_i), .pc_i(pc_i), .stall_o(stall_o), .redirect_o(redirect_o),
		.redirect_pc_o(redirect_pc_o), .wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o));

	always @(posedge clk) cycle++;

	function automatic string rec_name(int idx);
		return $sformatf("rec%0d_pc%0h", idx, idx * 4);
	endfunction

	// record idx-2 is a load in EX, record idx-1 its user in ID
	function automatic bit load_use_expected(int idx);
		logic [31:0] ld_w;
		logic [31:0] use_w;
		logic [3:0]  use_op;
		bit          rs1_read;
		bit          rs2_read;
		if (idx < 2)
			return 1'b0;
		if (idx >= 3 && td[(idx-3)*REC_W+4][0])
			return 1'b0;  // load slot squashed by a taken branch
		ld_w     = td[(idx-2)*REC_W];
		use_w    = td[(idx-1)*REC_W];
		use_op   = use_w[31:28];
		rs1_read = (use_op >= backend_pkg::ADD) && (use_op <= backend_pkg::BEQ);
		rs2_read = ((use_op >= backend_pkg::ADD) && (use_op <= backend_pkg::XOR))
			|| (use_op == backend_pkg::SW) || (use_op == backend_pkg::BEQ);
		return (ld_w[31:28] == backend_pkg::LW) && (ld_w[27:24] != 4'd0)
			&& ((rs1_read && (use_w[23:20] == ld_w[27:24]))
			|| (rs2_read && (use_w[19:16] == ld_w[27:24])));
	endfunction

	task automatic report_mismatch(string test, string field, logic [31:0] exp_val,
		logic [31:0] act_val);
		$display("MISMATCH %s %s expected %0h actual %0h", test, field, exp_val, act_val);
		errors++;
	endtask

	task automatic report_failure(string msg);
		$display("ERROR: %s", msg);
		errors++;
	endtask

	task automatic check_retire();
		int idx;
		checks++;
		assert (retire_q.size() > 0)
		else report_failure($sformatf("unexpected retire of r%0d with value %0h",
			wb_addr_o, wb_data_o));
		if (retire_q.size() > 0) begin
			idx = retire_q.pop_front();
			assert (wb_addr_o == td[idx*REC_W+2][3:0])
			else report_mismatch(rec_name(idx), "wb_addr", td[idx*REC_W+2],
				32'(wb_addr_o));
			assert (wb_data_o == td[idx*REC_W+3])
			else report_mismatch(rec_name(idx), "wb_data", td[idx*REC_W+3], wb_data_o);
			// accepted edge to the edge that raised wb_valid_o
			assert (cycle - accept_edge[idx] == latency[idx])
			else report_mismatch(rec_name(idx), "latency", 32'(latency[idx]),
				32'(cycle - accept_edge[idx]));
		end
	endtask

	task automatic check_redirect();
		int idx;
		checks++;
		assert (redirect_q.size() > 0)
		else report_failure($sformatf("unexpected redirect to %0h", redirect_pc_o));
		if (redirect_q.size() > 0) begin
			idx = redirect_q.pop_front();
			assert (redirect_pc_o == td[idx*REC_W+5])
			else report_mismatch(rec_name(idx), "redirect_pc", td[idx*REC_W+5],
				redirect_pc_o);
			// EX edge is three edges ahead of the retire edge
			assert (cycle - accept_edge[idx] == latency[idx] - 3)
			else report_mismatch(rec_name(idx), "redirect_cycle", 32'(latency[idx] - 3),
				32'(cycle - accept_edge[idx]));
		end
	endtask

	// outputs sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (wb_valid_o)
				check_retire();
			if (redirect_o)
				check_redirect();
		end
	end

	task automatic wait_reset(output bit ok);
		int waits;
		ok = 1'b1;
		waits = 0;
		while (rst_n !== 1'b1) begin
			if (waits >= RESET_LIMIT) begin
				report_failure("reset never released");
				ok = 1'b0;
				return;
			end
			@(posedge clk);
			waits++;
		end
	endtask

	task automatic run_stream(output bit ok);
		int idx;
		int waits;
		bit exp_stall;
		ok = 1'b1;
		idx = 0;
		while (idx < MAX_RECS && td[idx*REC_W] !== 32'hffff_ffff) begin
			issue_i = 1'b1;
			instr_i = td[idx*REC_W];
			pc_i    = 32'(idx * 4);
			@(negedge clk);
			exp_stall = load_use_expected(idx);
			assert (stall_o == exp_stall)
			else report_mismatch(rec_name(idx), "stall", 32'(exp_stall), 32'(stall_o));
			if (exp_stall)
				latency[idx-1]++;  // user held one cycle in ID
			waits = 0;
			while (stall_o) begin
				waits++;
				if (waits > STALL_LIMIT) begin
					report_failure($sformatf("stall_o stuck high while offering %s",
						rec_name(idx)));
					ok = 1'b0;
					return;
				end
				@(posedge clk);
				#1;
				@(negedge clk);
			end
			// taken at the coming edge
			accept_edge[idx] = cycle + 1;
			latency[idx]     = 4;
			if (td[idx*REC_W+1][0])
				retire_q.push_back(idx);
			if (td[idx*REC_W+4][0])
				redirect_q.push_back(idx);
			@(posedge clk);
			#1;
			idx++;
		end
		issue_i = 1'b0;
		instr_i = '0;
	endtask

	task automatic drain(output bit ok);
		int waits;
		ok = 1'b1;
		waits = 0;
		while (retire_q.size() > 0 || redirect_q.size() > 0) begin
			if (waits >= DRAIN_LIMIT) begin
				report_failure($sformatf("%0d retires and %0d redirects never seen",
					retire_q.size(), redirect_q.size()));
				ok = 1'b0;
				return;
			end
			@(posedge clk);
			waits++;
		end
		repeat (6) @(posedge clk);  // catch late extra retires
	endtask

	initial begin
		bit ok;
		issue_i = 1'b0;
		instr_i = '0;
		pc_i    = '0;
		errors  = 0;
		checks  = 0;
		$readmemh("verif/backend_testdata.hex", td);
		ok = !$isunknown(td[0]);
		assert (ok)
		else report_failure("test data file could not be read");
		if (ok)
			wait_reset(ok);
		if (ok) begin
			@(negedge clk);
			assert (!stall_o && !wb_valid_o && !redirect_o)
			else report_failure("outputs not idle after reset");
			@(posedge clk);
			#1;
			run_stream(ok);
		end
		if (ok)
			drain(ok);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* verif/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // period 8
	end

	// reset held low over the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule
